// ==== design/constantGenerator.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Constant generator
// Turns the R2 and R3 source encodings into the six fixed constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module constantGenerator import cpuPkg::*; (
    input  instrFields_t fields,
    output word_t        cgValue,
    output logic         cgActive   // High when cgValue replaces the register
);

    always_comb begin
        cgValue  = '0;
        cgActive = 1'b0;
        if (fields.srcReg == regCg) begin
            cgActive = 1'b1;  // Every R3 mode is a constant
            case (fields.as)
                modeRegister: cgValue = 16'h0000;
                modeIndexed:  cgValue = 16'h0001;
                modeIndirect: cgValue = 16'h0002;
                modeAutoInc:  cgValue = 16'hFFFF;
            endcase
        end else if (fields.srcReg == regSr && fields.as[1]) begin
            cgActive = 1'b1;
            cgValue  = (fields.as == modeIndirect) ? 16'h0004 : 16'h0008;
        end
        // R2 in register mode reads SR itself
    end

endmodule

// ==== design/cpuCore.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU core top level
// Ties the sequencer, register file, constant generator, operand fetch
// and function unit to the synchronous memory bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module cpuCore import cpuPkg::*; (
    input  logic  MCLK,
    input  logic  reset,
    input  word_t MDBin,   // Read data for the current MAB
    output word_t MAB,
    output word_t MDBout,
    output logic  MW,      // Write strobe, one cycle per write
    output logic  BW       // Byte write, lane chosen by MAB[0]
);

    // Decode and control from the sequencer
    instrFields_t fields;
    controlWord_t ctrl;

    // Register file outputs
    word_t        pc;
    word_t        srcValue;
    word_t        dstValue;
    statusFlags_t flags;

    // Constant generator outputs
    word_t cgValue;
    logic  cgActive;

    // Operands and address
    word_t srcOperand;
    word_t dstOperand;
    word_t effAddr;

    // ALU results
    word_t        result;
    statusFlags_t newFlags;

    instructionSequencer sequencer_i (
        .MCLK(MCLK), .reset(reset), .MDBin(MDBin),
        .pc(pc), .effAddr(effAddr), .result(result),
        .fields(fields), .ctrl(ctrl),
        .MAB(MAB), .MDBout(MDBout), .MW(MW), .BW(BW)
    );

    registerFile regFile_i (
        .MCLK(MCLK), .reset(reset), .fields(fields), .ctrl(ctrl),
        .result(result), .newFlags(newFlags),
        .pc(pc), .srcValue(srcValue), .dstValue(dstValue), .flags(flags)
    );

    constantGenerator constGen_i (
        .fields(fields), .cgValue(cgValue), .cgActive(cgActive)
    );

    operandFetch opFetch_i (
        .MCLK(MCLK), .reset(reset), .fields(fields), .ctrl(ctrl), .MDBin(MDBin),
        .srcValue(srcValue), .dstValue(dstValue),
        .cgValue(cgValue), .cgActive(cgActive),
        .srcOperand(srcOperand), .dstOperand(dstOperand), .effAddr(effAddr)
    );

    functionUnit alu_i (
        .fields(fields), .srcOperand(srcOperand), .dstOperand(dstOperand),
        .flags(flags), .result(result), .newFlags(newFlags)
    );

endmodule

// ==== design/cpuPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU package for the 16-bit MSP430-style core
// Holds the word type, the Format I opcodes and addressing modes, the
// decoded instruction fields, the sequencer strobes and the state enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpuPkg;

    typedef logic [15:0] word_t;  // Data and address words share one width

    localparam word_t resetPc = 16'hC000;  // First fetch address after reset

    // Format I opcodes live in the top nibble of the instruction word
    localparam logic [3:0] opMov  = 4'h4;
    localparam logic [3:0] opAdd  = 4'h5;
    localparam logic [3:0] opAddc = 4'h6;
    localparam logic [3:0] opSubc = 4'h7;
    localparam logic [3:0] opSub  = 4'h8;
    localparam logic [3:0] opCmp  = 4'h9;
    localparam logic [3:0] opBit  = 4'hB;
    localparam logic [3:0] opBic  = 4'hC;
    localparam logic [3:0] opBis  = 4'hD;
    localparam logic [3:0] opXor  = 4'hE;
    localparam logic [3:0] opAnd  = 4'hF;

    // Source addressing modes as encoded in the As field
    localparam logic [1:0] modeRegister = 2'b00;
    localparam logic [1:0] modeIndexed  = 2'b01;
    localparam logic [1:0] modeIndirect = 2'b10;
    localparam logic [1:0] modeAutoInc  = 2'b11;

    // Registers with a special role
    localparam logic [3:0] regPc = 4'd0;
    localparam logic [3:0] regSp = 4'd1;
    localparam logic [3:0] regSr = 4'd2;
    localparam logic [3:0] regCg = 4'd3;

    // Flags as kept in SR bits 8, 2, 1 and 0
    typedef struct packed {
        logic v;
        logic n;
        logic z;
        logic c;
    } statusFlags_t;

    // Field order matches the instruction word so a cast decodes it
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] srcReg;
        logic       ad;      // Destination mode, 1 selects x(Rn)
        logic       byteOp;  // B/W bit
        logic [1:0] as;
        logic [3:0] dstReg;
    } instrFields_t;

    // One strobe per datapath action, at most a few high per state
    typedef struct packed {
        logic pcInc;
        logic latchSrcExt;
        logic latchIndex;
        logic latchDstMem;
        logic exec;
        logic regWrite;
        logic memWrite;
        logic flagWrite;
    } controlWord_t;

    typedef enum logic [2:0] {
        stFetch,
        stSrcExt,
        stDstExt,
        stDstRead,
        stExec
    } seqState_t;

endpackage

// ==== design/functionUnit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Function unit
// Combinational ALU for the Format I operations, with V, N, Z and C
// generated at byte or word width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module functionUnit import cpuPkg::*; (
    input  instrFields_t fields,
    input  word_t        srcOperand,   // Already masked to 8 bits for byte ops
    input  word_t        dstOperand,
    input  statusFlags_t flags,
    output word_t        result,
    output statusFlags_t newFlags
);

    word_t       srcInv;    // Source inverted within the operation width
    word_t       addB;      // Second adder input
    logic        carryIn;
    logic [16:0] sum;
    logic        carryOut;
    logic        msbA;
    logic        msbB;
    logic        msbR;
    logic        isZero;
    logic        isArith;

    assign srcInv = fields.byteOp ? {8'h00, ~srcOperand[7:0]} : ~srcOperand;

    // Subtraction is dst + ~src + carry
    always_comb begin
        addB    = srcOperand;
        carryIn = 1'b0;
        isArith = 1'b1;
        case (fields.opcode)
            opAdd:        carryIn = 1'b0;
            opAddc:       carryIn = flags.c;
            opSubc: begin
                addB    = srcInv;
                carryIn = flags.c;
            end
            opSub, opCmp: begin
                addB    = srcInv;
                carryIn = 1'b1;
            end
            default:      isArith = 1'b0;
        endcase
    end

    assign sum      = {1'b0, dstOperand} + {1'b0, addB} + {16'd0, carryIn};
    assign carryOut = fields.byteOp ? sum[8] : sum[16];

    always_comb begin
        case (fields.opcode)
            opMov:              result = srcOperand;
            opBit, opAnd:       result = dstOperand & srcOperand;
            opBic:              result = dstOperand & ~srcOperand;
            opBis:              result = dstOperand | srcOperand;
            opXor:              result = dstOperand ^ srcOperand;
            default:            result = isArith ? sum[15:0] : dstOperand;
        endcase
        if (fields.byteOp) result[15:8] = 8'h00;  // Keep byte results inside the low lane
    end

    // Sign bits at the operation width
    assign msbA   = fields.byteOp ? dstOperand[7] : dstOperand[15];
    assign msbB   = fields.byteOp ? addB[7] : addB[15];
    assign msbR   = fields.byteOp ? result[7] : result[15];
    assign isZero = fields.byteOp ? (result[7:0] == 8'h00) : (result == 16'h0000);

    always_comb begin
        newFlags.n = msbR;
        newFlags.z = isZero;
        if (isArith) begin
            newFlags.c = carryOut;
            newFlags.v = (msbA == msbB) && (msbR != msbA);  // Same-sign inputs, sign flipped
        end else begin
            newFlags.c = !isZero;  // Logical ops report a nonzero result in C
            newFlags.v = (fields.opcode == opXor)
                       && (fields.byteOp ? srcOperand[7] : srcOperand[15]) && msbA;
        end
        // MOV, BIC, BIS and unknown opcodes keep SR as is
        if (fields.opcode == opMov || fields.opcode == opBic || fields.opcode == opBis
                || !(isArith || fields.opcode == opBit || fields.opcode == opAnd
                || fields.opcode == opXor)) begin
            newFlags = flags;
        end
    end

endmodule

// ==== design/instructionSequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction sequencer
// Holds the instruction register and the five-state FSM, issues the
// datapath strobes and drives the memory address and write data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module instructionSequencer import cpuPkg::*; (
    input  logic         MCLK,
    input  logic         reset,
    input  word_t        MDBin,
    input  word_t        pc,
    input  word_t        effAddr,
    input  word_t        result,
    output instrFields_t fields,
    output controlWord_t ctrl,
    output word_t        MAB,
    output word_t        MDBout,
    output logic         MW,
    output logic         BW
);

    seqState_t    state;
    seqState_t    nextState;
    instrFields_t instrReg;
    instrFields_t fetched;     // Word on the bus during FETCH
    logic         writesDst;   // CMP and BIT only set flags

    assign fetched = instrFields_t'(MDBin);
    assign fields  = instrReg;

    // Only @PC+ brings an extension word for the source
    function automatic logic needsImmediate(instrFields_t f);
        return (f.as == modeAutoInc) && (f.srcReg == regPc);
    endfunction

    always_ff @(posedge MCLK) begin
        if (reset) begin
            state    <= stFetch;
            instrReg <= '0;
        end else begin
            state <= nextState;
            if (state == stFetch) begin
                instrReg <= fetched;  // IR follows the fetched word
            end
        end
    end

    // Extension words come in the order source then index
    always_comb begin
        nextState = stFetch;
        case (state)
            stFetch: begin
                if (needsImmediate(fetched)) nextState = stSrcExt;
                else if (fetched.ad)         nextState = stDstExt;
                else                         nextState = stExec;
            end
            stSrcExt:  nextState = instrReg.ad ? stDstExt : stExec;
            stDstExt:  nextState = stDstRead;
            stDstRead: nextState = stExec;
            stExec:    nextState = stFetch;
            default:   nextState = stFetch;
        endcase
    end

    assign writesDst = (instrReg.opcode >= opMov)
                     && (instrReg.opcode != opCmp) && (instrReg.opcode != opBit);

    always_comb begin
        ctrl = '0;
        case (state)
            stFetch:  ctrl.pcInc = 1'b1;
            stSrcExt: begin
                ctrl.pcInc       = 1'b1;
                ctrl.latchSrcExt = 1'b1;
            end
            stDstExt: begin
                ctrl.pcInc      = 1'b1;
                ctrl.latchIndex = 1'b1;
            end
            stDstRead: ctrl.latchDstMem = 1'b1;
            stExec: begin
                ctrl.exec      = 1'b1;
                ctrl.regWrite  = writesDst && !instrReg.ad;
                ctrl.memWrite  = writesDst && instrReg.ad;
                // MOV, BIC and BIS leave the flags alone
                ctrl.flagWrite = (instrReg.opcode >= opMov) && (instrReg.opcode != opMov)
                               && (instrReg.opcode != opBic) && (instrReg.opcode != opBis);
            end
            default: ctrl = '0;
        endcase
    end

    // Operand read and the write-back of an indexed destination use effAddr
    assign MAB = (ctrl.latchDstMem || (ctrl.exec && instrReg.ad)) ? effAddr : pc;

    assign MW     = ctrl.memWrite;
    assign BW     = ctrl.memWrite && instrReg.byteOp;  // Memory picks the lane from MAB[0]
    assign MDBout = instrReg.byteOp ? {result[7:0], result[7:0]} : result;

endmodule

// ==== design/operandFetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand fetch
// Picks the source operand, latches extension words and the memory
// operand, forms the x(Rn) address and extracts byte lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module operandFetch import cpuPkg::*; (
    input  logic         MCLK,
    input  logic         reset,
    input  instrFields_t fields,
    input  controlWord_t ctrl,
    input  word_t        MDBin,
    input  word_t        srcValue,
    input  word_t        dstValue,
    input  word_t        cgValue,
    input  logic         cgActive,
    output word_t        srcOperand,
    output word_t        dstOperand,
    output word_t        effAddr
);

    word_t immWord;    // Word after the instruction for @PC+
    word_t indexWord;  // Offset for x(Rn)
    word_t memWord;    // Destination word read in DSTREAD
    word_t srcRaw;
    word_t dstRaw;

    always_ff @(posedge MCLK) begin
        if (reset) begin
            indexWord <= '0;
        end else if (ctrl.latchIndex) begin
            indexWord <= MDBin;
        end
    end

    always_ff @(posedge MCLK) begin
        if (ctrl.latchSrcExt) immWord <= MDBin;
        if (ctrl.latchDstMem) memWord <= MDBin;
    end

    assign effAddr = dstValue + indexWord;

    assign srcRaw = cgActive ? cgValue
                  : (fields.as == modeAutoInc && fields.srcReg == regPc) ? immWord
                  : srcValue;

    // An odd address means the operand sits in the high lane
    assign dstRaw = !fields.ad ? dstValue
                  : (fields.byteOp && effAddr[0]) ? {8'h00, memWord[15:8]}
                  : memWord;

    assign srcOperand = fields.byteOp ? {8'h00, srcRaw[7:0]} : srcRaw;
    assign dstOperand = fields.byteOp ? {8'h00, dstRaw[7:0]} : dstRaw;

endmodule

// ==== design/registerFile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file R0 to R15
// R0 is the PC, R2 keeps the V, N, Z and C flags, and results are
// written back to the destination register at the end of EXEC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module registerFile import cpuPkg::*; (
    input  logic         MCLK,
    input  logic         reset,
    input  instrFields_t fields,
    input  controlWord_t ctrl,
    input  word_t        result,
    input  statusFlags_t newFlags,
    output word_t        pc,
    output word_t        srcValue,
    output word_t        dstValue,
    output statusFlags_t flags
);

    word_t regs [16];
    word_t wbValue;   // Result as it lands in the register

    // Byte results zero the upper half of a register destination
    always_comb begin
        wbValue = fields.byteOp ? {8'h00, result[7:0]} : result;
        if (fields.dstReg == regSp) begin
            wbValue[0] = 1'b0;  // Stack pointer stays word aligned
        end
    end

    always_ff @(posedge MCLK) begin
        if (reset) begin
            regs[regPc] <= resetPc;
            regs[regSr] <= '0;
        end else begin
            if (ctrl.pcInc) begin
                regs[regPc] <= regs[regPc] + 16'd2;  // Every bus word read through PC advances it
            end
            if (ctrl.flagWrite) begin
                regs[regSr][8] <= newFlags.v;
                regs[regSr][2] <= newFlags.n;
                regs[regSr][1] <= newFlags.z;
                regs[regSr][0] <= newFlags.c;
            end
            if (ctrl.regWrite) begin
                regs[fields.dstReg] <= wbValue;
            end
        end
    end

    assign pc       = regs[regPc];
    assign srcValue = regs[fields.srcReg];
    assign dstValue = regs[fields.dstReg];  // Also the base for x(Rn)

    assign flags.v = regs[regSr][8];
    assign flags.n = regs[regSr][2];
    assign flags.z = regs[regSr][1];
    assign flags.c = regs[regSr][0];

endmodule

// ==== filelist.f ====
+incdir+verif
design/cpuPkg.sv
design/instructionSequencer.sv
design/registerFile.sv
design/constantGenerator.sv
design/operandFetch.sv
design/functionUnit.sv
design/cpuCore.sv
verif/cpuCore_props.sv
verif/cpuCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb \
    -f filelist.f --Mdir obj_dir -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    exit 1
fi
exit 0

// ==== verif/cpuCoreModel.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction-level reference model of the CPU core
// Executes one Format I instruction at a time and queues the memory
// writes that the core is expected to make, in program order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_CORE_MODEL_SVH
`define CPU_CORE_MODEL_SVH

word_t      modelReg [16];
logic       modelV, modelN, modelZ, modelC;
logic [7:0] modelMem [0:65535];
word_t      expAddr [$];   // Expected write address
word_t      expData [$];   // Word, or byte in the low half
logic       expByte [$];

// R2 reads back as the flag bits only, all other SR bits stay zero
function automatic word_t modelRead(input logic [3:0] r);
    if (r == 4'd2) return {7'd0, modelV, 5'd0, modelN, modelZ, modelC};
    return modelReg[r];
endfunction

task automatic modelStep(input word_t instr, input word_t srcExt, input word_t idx);
    logic [3:0]  op;
    logic [3:0]  sr;
    logic [3:0]  dr;
    logic [1:0]  as;
    logic        ad;
    logic        bw;
    word_t       msk;
    word_t       s;
    word_t       d;
    word_t       b;
    word_t       r;
    word_t       ea;
    logic [16:0] acc;
    logic        arith;
    int          sb;
    op = instr[15:12];
    sr = instr[11:8];
    ad = instr[7];
    bw = instr[6];
    as = instr[5:4];
    dr = instr[3:0];
    msk = bw ? 16'h00FF : 16'hFFFF;
    sb = bw ? 7 : 15;  // Sign bit at the operation width
    if (sr == 4'd3) s = (as == 2'd0) ? 16'h0000 : (as == 2'd1) ? 16'h0001
                      : (as == 2'd2) ? 16'h0002 : 16'hFFFF;
    else if (sr == 4'd2 && as[1]) s = as[0] ? 16'h0008 : 16'h0004;
    else if (sr == 4'd0 && as == 2'd3) s = srcExt;  // Immediate word
    else s = modelRead(sr);
    s = s & msk;
    ea = modelReg[dr] + idx;
    if (!ad) d = modelRead(dr) & msk;
    else if (bw) d = {8'h00, modelMem[ea]};  // Only the addressed lane
    else d = {modelMem[ea + 16'd1], modelMem[ea]};
    arith = (op >= 4'h5) && (op <= 4'h9);
    b = (op >= 4'h7) ? (~s & msk) : s;   // SUBC, SUB and CMP add the complement
    acc = {1'b0, d} + {1'b0, b}
        + ((op == 4'h6 || op == 4'h7) ? {16'd0, modelC} : (op >= 4'h8) ? 17'd1 : 17'd0);
    case (op)
        4'h4:       r = s;
        4'hB, 4'hF: r = d & s;
        4'hC:       r = d & ~s;
        4'hD:       r = d | s;
        4'hE:       r = d ^ s;
        default:    r = acc[15:0];
    endcase
    r = r & msk;
    if (op != 4'h4 && op != 4'hC && op != 4'hD) begin  // These leave SR alone
        modelN = r[sb];
        modelZ = (r == 16'h0000);
        modelC = arith ? acc[sb + 1] : !modelZ;
        if (!arith) modelV = (op == 4'hE) && s[sb] && d[sb];
        else if (op >= 4'h7) modelV = (s[sb] != d[sb]) && (r[sb] != d[sb]);  // d minus s
        else modelV = (s[sb] == d[sb]) && (r[sb] != d[sb]);  // d plus s
    end
    if (op == 4'h9 || op == 4'hB) return;  // CMP and BIT only touch flags
    if (!ad) begin
        modelReg[dr] = r;
    end else begin
        expAddr.push_back(ea);
        expData.push_back(r);
        expByte.push_back(bw);
        modelMem[ea] = r[7:0];
        if (!bw) modelMem[ea + 16'd1] = r[15:8];
    end
endtask

`endif

// ==== verif/cpuCoreTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the CPU core
// Builds random programs per test category, runs them from a byte
// memory model and checks every bus write against the reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module cpuCoreTb import cpuPkg::*; ();

    localparam int    numTests   = 5;
    localparam int    blockLen   = 24;
    localparam int    maxInstr   = 1 + 11 + blockLen + 12;  // Init, random block, stores
    localparam int    limitNs    = numTests * maxInstr * 5 * 20 * 2;
    localparam word_t dataBase   = 16'h2000;
    localparam word_t storeOff   = 16'h0100;  // R5..R15 land at storeOff + 2n
    localparam word_t srOff      = 16'h0140;

    logic       MCLK;
    logic       reset;
    word_t      MDBin;
    word_t      MAB;
    word_t      MDBout;
    logic       MW;
    logic       BW;
    logic [7:0] mem [0:65535];
    integer     seed;
    word_t      progAddr;
    word_t      progEnd;
    word_t      lastMab;       // Last program address seen on the bus
    logic       running;
    int         testErrors;
    int         totalErrors;
    int         writesSeen;
    string      curTest;
    string      testNames [numTests] = '{"wordRegReg", "immConst", "byteOps",
                                         "indexedRmw", "mixedFlags"};

    `include "cpuCoreModel.svh"

    cpuCore dut_i (.MCLK(MCLK), .reset(reset), .MDBin(MDBin), .MAB(MAB),
                   .MDBout(MDBout), .MW(MW), .BW(BW));

    initial begin
        MCLK = 1'b0;
        forever #10 MCLK = ~MCLK;
    end

    // Reads return the aligned word, writes honour the byte lane
    assign MDBin = {mem[{MAB[15:1], 1'b1}], mem[{MAB[15:1], 1'b0}]};

    always @(posedge MCLK) begin
        if (MW && BW) mem[MAB] <= MAB[0] ? MDBout[15:8] : MDBout[7:0];
        else if (MW) begin
            mem[MAB]         <= MDBout[7:0];
            mem[MAB + 16'd1] <= MDBout[15:8];
        end
    end

    task automatic checkWord(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("** Error %s: %s expected %h actual %h", curTest, what, exp, act);
            testErrors++;
        end
    endtask

    task automatic checkBit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error %s: %s expected %b actual %b", curTest, what, exp, act);
            testErrors++;
        end
    endtask

    // Mid-cycle sampling, outputs settled since the last rising edge
    always @(negedge MCLK) begin
        if (running && MW) begin
            writesSeen++;
            if (expAddr.size() == 0) begin
                $display("%s: write to address %h when no write was expected", curTest, MAB);
                testErrors++;
            end else begin
                checkWord("write address", expAddr.pop_front(), MAB);
                checkBit("byte write", expByte[0], BW);
                if (expByte.pop_front()) begin
                    checkWord("byte data", expData.pop_front(),
                              {8'h00, MAB[0] ? MDBout[15:8] : MDBout[7:0]});
                end else begin
                    checkWord("word data", expData.pop_front(), MDBout);
                end
            end
        end
        if (running && MAB >= resetPc && MAB < progEnd) begin
            if (MAB != lastMab && MAB != lastMab + 16'd2) begin
                $display("%s: fetch address %h out of sequence after %h", curTest, MAB, lastMab);
                testErrors++;
            end
            lastMab = MAB;
        end
    end

    function automatic logic [7:0] fillByte(input word_t a);
        return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h5A;
    endfunction

    function automatic logic [3:0] pickOp(input int k);
        case (k)
            0:       return opMov;
            1:       return opAdd;
            2:       return opAddc;
            3:       return opSubc;
            4:       return opSub;
            5:       return opCmp;
            6:       return opBit;
            7:       return opBic;
            8:       return opBis;
            9:       return opXor;
            default: return opAnd;
        endcase
    endfunction

    task automatic emit(input word_t w);
        mem[progAddr]         = w[7:0];
        mem[progAddr + 16'd1] = w[15:8];
        progAddr              = progAddr + 16'd2;
    endtask

    // Places one instruction with its extension words and runs it in the model
    task automatic issue(input logic [3:0] op, input logic [3:0] sr, input logic [1:0] as,
                         input logic bw, input logic ad, input logic [3:0] dr,
                         input word_t ext, input word_t idx);
        word_t instr;
        instr = {op, sr, ad, bw, as, dr};
        emit(instr);
        if (sr == regPc && as == modeAutoInc) emit(ext);
        if (ad) emit(idx);
        modelStep(instr, ext, idx);
    endtask

    task automatic randomInstr(input int cat, input int i);
        logic [3:0] op;
        logic [3:0] sr;
        logic [1:0] as;
        logic [3:0] dr;
        logic       bw;
        logic       ad;
        int         kind;
        int         cg;
        op   = pickOp({$random(seed)} % 11);
        kind = {$random(seed)} % 3;   // Register, immediate or constant
        cg   = {$random(seed)} % 6;
        bw   = $random(seed);
        ad   = $random(seed);
        case (cat)
            0: begin
                kind = 0;
                bw   = 0;
                ad   = 0;
            end
            1: begin
                kind = (i % 7 == 6) ? 1 : 2;  // Six constants in turn, then one immediate
                cg   = i % 7;
                bw   = 0;
                ad   = 0;
            end
            2: bw = 1;
            3: begin
                bw = 0;
                ad = 1;
            end
            default: ;
        endcase
        sr = (kind == 0) ? 4'd4 + 4'({$random(seed)} % 12) : (kind == 1) ? regPc
           : (cg < 4) ? regCg : regSr;
        as = (kind == 0) ? modeRegister : (kind == 1) ? modeAutoInc
           : (cg < 4) ? 2'(cg) : (cg == 4) ? modeIndirect : modeAutoInc;
        dr = ad ? 4'd4 : 4'd5 + 4'({$random(seed)} % 11);  // Memory targets sit above R4
        issue(op, sr, as, bw, ad, dr, $random(seed),
              bw ? word_t'({$random(seed)} % 64) : word_t'(({$random(seed)} % 32) * 2));
    endtask

    task automatic buildProgram(input int cat);
        for (int a = 0; a < 65536; a++) begin
            mem[a]      = fillByte(word_t'(a));
            modelMem[a] = fillByte(word_t'(a));
        end
        expAddr.delete();
        expData.delete();
        expByte.delete();
        {modelV, modelN, modelZ, modelC} = 4'b0000;  // SR clears on reset
        progAddr = resetPc;
        issue(opMov, regPc, modeAutoInc, 1'b0, 1'b0, 4'd4, dataBase, '0);
        for (int n = 5; n < 16; n++) issue(opMov, regPc, modeAutoInc, 1'b0, 1'b0, 4'(n),
                                           $random(seed), '0);
        for (int i = 0; i < blockLen; i++) randomInstr(cat, i);
        for (int n = 5; n < 16; n++) issue(opMov, 4'(n), modeRegister, 1'b0, 1'b1, 4'd4,
                                           '0, storeOff + word_t'(2 * n));
        issue(opMov, regSr, modeRegister, 1'b0, 1'b1, 4'd4, '0, srOff);
        progEnd = progAddr;
    endtask

    initial begin
        int expected;
        reset       = 1'b1;
        running     = 1'b0;
        seed        = 32'h00222633;
        totalErrors = 0;
        progEnd     = resetPc;
        for (int t = 0; t < numTests; t++) begin
            curTest    = testNames[t];
            testErrors = 0;
            writesSeen = 0;
            reset      = 1'b1;
            buildProgram(t);
            expected = expAddr.size();
            repeat (2) @(negedge MCLK);
            reset = 1'b0;
            checkWord("first bus address", resetPc, MAB);
            checkBit("MW after reset", 1'b0, MW);
            checkBit("BW after reset", 1'b0, BW);
            lastMab = resetPc;
            running = 1'b1;
            while (expAddr.size() != 0) @(posedge MCLK);
            @(negedge MCLK);  // The last write has landed and the core is back in FETCH
            running = 1'b0;
            totalErrors += testErrors;
            $display("test %s: %0d of %0d writes seen, %0d errors", curTest, writesSeen,
                     expected, testErrors);
        end
        $display("tests run %0d, errors %0d", numTests, totalErrors);
        if (totalErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Bounds the whole run in case the core stops writing
    initial begin
        #(limitNs * 1ns);
        $display("Watchdog expired before all expected writes were seen in %s", curTest);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== verif/cpuCore_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus protocol assertions for the CPU core
// Bound to every instance of the core top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module cpuCore_props import cpuPkg::*; (
    input logic  MCLK,
    input logic  reset,
    input logic  MW,
    input logic  BW,
    input word_t MAB
);

    // A reset cycle always leaves the core in FETCH with no write
    assert property (@(posedge MCLK) reset |=> !MW)
        else $error("MW high in the cycle after reset");

    // Each write is the single EXEC cycle of one instruction
    assert property (@(posedge MCLK) disable iff (reset) MW |=> !MW)
        else $error("MW high in two consecutive cycles");

    assert property (@(posedge MCLK) disable iff (reset) (MW && !BW) |-> !MAB[0])
        else $error("Word write to an odd address");

endmodule

bind cpuCore cpuCore_props props_i (.*);
